// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // Address and instruction word width
    localparam int XLEN = 32;

    // Cache line geometry
    localparam int LINE_BITS   = 256;
    localparam int LINE_WORDS  = LINE_BITS / XLEN;
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);

    // First fetch group after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Cache controller
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        FILL,
        DONE
    } icache_state_t;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
module fetch_pc_gen #(
    parameter int IF_WIDTH = 2
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      flush,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc,

    input  logic                      prv_ready,
    output logic                      prv_valid,
    output logic [fetch_pkg::XLEN-1:0] pc_next
);

    localparam int GROUP_BYTES = IF_WIDTH * 4;
    localparam int GROUP_LSB   = $clog2(GROUP_BYTES);

    // Next group address, redirect wins over sequential advance
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_next   <= fetch_pkg::RESET_PC;
            prv_valid <= 1'b0;
        end else begin
            prv_valid <= 1'b1;
            if (flush) begin
                pc_next <= redirect_pc;
            end else if (prv_valid && prv_ready) begin
                pc_next <= pc_next + GROUP_BYTES;
            end
        end
    end

    // Redirect targets must also land on a group boundary
    a_group_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc_next[GROUP_LSB-1:0] == '0
    );

endmodule

// ==== hdl/icache.sv ====
module icache #(
    parameter int IF_WIDTH = 2,
    parameter int NUM_SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst,

    // Fetch side
    input  logic [fetch_pkg::XLEN-1:0]      ufp_addr,
    input  logic                           ufp_read,
    input  logic                           kill,
    output logic [fetch_pkg::XLEN-1:0]      ufp_rdata [IF_WIDTH],
    output logic                           ufp_resp,

    // Memory side, whole lines
    output logic [fetch_pkg::XLEN-1:0]      dfp_addr,
    output logic                           dfp_read,
    input  logic [fetch_pkg::LINE_BITS-1:0] dfp_rdata,
    input  logic                           dfp_resp
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = fetch_pkg::XLEN - fetch_pkg::OFFSET_BITS - INDEX_BITS;
    localparam int WORD_BITS  = $clog2(fetch_pkg::LINE_WORDS);
    localparam logic [WORD_BITS-1:0] GROUP_MASK = ~(WORD_BITS'(IF_WIDTH - 1));

    fetch_pkg::icache_state_t state;

    logic [TAG_BITS-1:0]             tag_arr [NUM_SETS];
    logic [fetch_pkg::LINE_BITS-1:0] data_arr [NUM_SETS];
    logic [NUM_SETS-1:0]             valid_arr;

    logic [fetch_pkg::XLEN-1:0]      req_addr;
    logic [fetch_pkg::XLEN-1:0]      fill_addr;
    logic                            live;

    logic [INDEX_BITS-1:0]           req_index;
    logic [TAG_BITS-1:0]             req_tag;
    logic [WORD_BITS-1:0]            group_base;
    logic [fetch_pkg::LINE_BITS-1:0] req_line;
    logic [INDEX_BITS-1:0]           fill_index;
    logic                            hit;
    logic                            lookup;
    logic                            new_req;
    logic                            start_fill;
    logic                            fill_write;

    assign req_index  = req_addr[fetch_pkg::OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = req_addr[fetch_pkg::XLEN-1 -: TAG_BITS];
    assign group_base = req_addr[fetch_pkg::OFFSET_BITS-1:2] & GROUP_MASK;
    assign req_line   = data_arr[req_index];
    assign fill_index = fill_addr[fetch_pkg::OFFSET_BITS +: INDEX_BITS];

    assign hit        = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
    assign lookup     = (state == fetch_pkg::COMPARE) || (state == fetch_pkg::DONE);
    assign new_req    = ufp_read && ~kill;
    assign start_fill = lookup && live && ~kill && ~hit && ~new_req;
    assign fill_write = (state == fetch_pkg::FILL) && dfp_resp;

    // Killed requests get no response
    assign ufp_resp = lookup && live && hit && ~kill;

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            ufp_rdata[i] = req_line[(int'(group_base) + i) * fetch_pkg::XLEN +: fetch_pkg::XLEN];
        end
    end

    assign dfp_read = (state == fetch_pkg::FILL);
    assign dfp_addr = fill_addr;

    // Outstanding request tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
        end else if (kill) begin
            live <= 1'b0;
        end else if (ufp_read) begin
            live <= 1'b1;
        end else if (ufp_resp) begin
            live <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            req_addr <= ufp_addr;
        end
        if (start_fill) begin
            fill_addr <= {req_addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                          {fetch_pkg::OFFSET_BITS{1'b0}}};
        end
    end

    // DONE looks up again once the line is in the array
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::IDLE;
        end else begin
            case (state)
                fetch_pkg::IDLE: begin
                    if (new_req) begin
                        state <= fetch_pkg::COMPARE;
                    end
                end
                fetch_pkg::COMPARE, fetch_pkg::DONE: begin
                    if (new_req) begin
                        state <= fetch_pkg::COMPARE;
                    end else if (start_fill) begin
                        state <= fetch_pkg::FILL;
                    end else begin
                        state <= fetch_pkg::IDLE;
                    end
                end
                fetch_pkg::FILL: begin
                    if (dfp_resp) begin
                        state <= fetch_pkg::DONE;
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    // Line refill completes even after a kill
    always_ff @(posedge clk) begin
        if (fill_write) begin
            data_arr[fill_index] <= dfp_rdata;
            tag_arr[fill_index]  <= fill_addr[fetch_pkg::XLEN-1 -: TAG_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if (fill_write) begin
            valid_arr[fill_index] <= 1'b1;
        end
    end

    a_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        ufp_read && live && ~ufp_resp |-> kill
    );

    a_fill_held: assert property (
        @(posedge clk) disable iff (rst)
        dfp_read && ~dfp_resp |=> dfp_read && $stable(dfp_addr)
    );

    a_resp_only_in_fill: assert property (
        @(posedge clk) disable iff (rst)
        dfp_resp |-> state == fetch_pkg::FILL
    );

endmodule

// ==== hdl/if1_stage.sv ====
module if1_stage #(
    parameter int IF_WIDTH = 2,
    parameter int NUM_SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,

    input  logic                           prv_valid,
    output logic                           prv_ready,

    output logic                           nxt_valid,
    input  logic                           nxt_ready,

    input  logic [fetch_pkg::XLEN-1:0]      pc_next,
    output logic [fetch_pkg::XLEN-1:0]      pc,
    output logic [fetch_pkg::XLEN-1:0]      insts [IF_WIDTH],

    output logic [fetch_pkg::XLEN-1:0]      dfp_addr,
    output logic                           dfp_read,
    input  logic [fetch_pkg::LINE_BITS-1:0] dfp_rdata,
    input  logic                           dfp_resp
);

    logic                       icache_valid;
    logic                       icache_pending;
    logic                       waiting;
    logic                       consume;

    logic [fetch_pkg::XLEN-1:0] ufp_addr;
    logic                       ufp_read;
    logic [fetch_pkg::XLEN-1:0] ufp_rdata [IF_WIDTH];
    logic                       ufp_resp;
    logic                       kill;
    logic [fetch_pkg::XLEN-1:0] temp_rdata [IF_WIDTH];

    assign prv_ready = ~icache_valid || (nxt_valid && nxt_ready) || flush;
    assign consume   = nxt_valid && nxt_ready;

    // Address taken during a flush is stale
    assign ufp_addr = pc_next;
    assign ufp_read = prv_valid && prv_ready && ~flush;
    assign kill     = flush;

    always_ff @(posedge clk) begin
        if (ufp_read) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            icache_pending <= 1'b0;
            icache_valid   <= 1'b0;
        end else begin
            if (ufp_read) begin
                icache_pending <= 1'b1;
            end else if (ufp_resp) begin
                icache_pending <= 1'b0;
            end
            if (ufp_read) begin
                icache_valid <= 1'b1;
            end else if (consume) begin
                icache_valid <= 1'b0;
            end
        end
    end

    icache #(
        .IF_WIDTH (IF_WIDTH),
        .NUM_SETS (NUM_SETS)
    ) i_icache (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_read  (ufp_read),
        .kill      (kill),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    // Holds the group while the consumer stalls
    always_ff @(posedge clk) begin
        if (ufp_resp) begin
            temp_rdata <= ufp_rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            insts[i] = ufp_resp ? ufp_rdata[i] : temp_rdata[i];
        end
    end

    assign waiting   = icache_pending && ~ufp_resp;
    assign nxt_valid = icache_valid && ~waiting && ~flush;

    a_stall_stable: assert property (
        @(posedge clk) disable iff (rst)
        nxt_valid && ~nxt_ready && ~flush |=> $stable(pc) && $stable(insts[0])
    );

endmodule

// ==== hdl/fetch_top.sv ====
module fetch_top #(
    parameter int IF_WIDTH = 2,
    parameter int NUM_SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           redirect,
    input  logic [fetch_pkg::XLEN-1:0]      redirect_pc,

    output logic                           fetch_valid,
    input  logic                           fetch_ready,
    output logic [fetch_pkg::XLEN-1:0]      fetch_pc,
    output logic [fetch_pkg::XLEN-1:0]      fetch_insts [IF_WIDTH],

    output logic [fetch_pkg::XLEN-1:0]      dfp_addr,
    output logic                           dfp_read,
    input  logic [fetch_pkg::LINE_BITS-1:0] dfp_rdata,
    input  logic                           dfp_resp
);

    logic                       prv_valid;
    logic                       prv_ready;
    logic [fetch_pkg::XLEN-1:0] pc_next;

    fetch_pc_gen #(
        .IF_WIDTH (IF_WIDTH)
    ) i_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .flush       (redirect),
        .redirect_pc (redirect_pc),
        .prv_ready   (prv_ready),
        .prv_valid   (prv_valid),
        .pc_next     (pc_next)
    );

    if1_stage #(
        .IF_WIDTH (IF_WIDTH),
        .NUM_SETS (NUM_SETS)
    ) i_if1 (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .prv_valid (prv_valid),
        .prv_ready (prv_ready),
        .nxt_valid (fetch_valid),
        .nxt_ready (fetch_ready),
        .pc_next   (pc_next),
        .pc        (fetch_pc),
        .insts     (fetch_insts),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

endmodule

// ==== tests/line_mem_model.sv ====
module line_mem_model #(
    parameter int DELAY = 6
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [fetch_pkg::XLEN-1:0]      dfp_addr,
    input  logic                           dfp_read,
    output logic [fetch_pkg::LINE_BITS-1:0] dfp_rdata,
    output logic                           dfp_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                       busy;
    int                         count;
    logic [fetch_pkg::XLEN-1:0] line_addr;

    // Each word holds its own byte address XOR a fixed pattern
    function automatic logic [fetch_pkg::LINE_BITS-1:0] line_data(
        input logic [fetch_pkg::XLEN-1:0] base
    );
        logic [fetch_pkg::LINE_BITS-1:0] data;
        for (int k = 0; k < fetch_pkg::LINE_WORDS; k++) begin
            data[k*fetch_pkg::XLEN +: fetch_pkg::XLEN] = (base + 32'(4 * k)) ^ 32'hA5A5_0000;
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            count     <= 0;
            dfp_resp  <= 1'b0;
            dfp_rdata <= '0;
        end else begin
            dfp_resp <= 1'b0;
            if (dfp_resp) begin
                busy <= 1'b0;
            end else if (!busy && dfp_read) begin
                busy      <= 1'b1;
                count     <= DELAY - 1;
                // A misaligned request shifts every word of the line
                line_addr <= dfp_addr;
            end else if (busy) begin
                if (count == 0) begin
                    dfp_resp  <= 1'b1;
                    dfp_rdata <= line_data(line_addr);
                end else begin
                    count <= count - 1;
                end
            end
        end
    end

endmodule

// ==== tests/tb_fetch.sv ====
module tb_fetch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IF_WIDTH    = 2;
    localparam int NUM_SETS    = 16;
    localparam int CLK_PERIOD  = 4;
    localparam int WAIT_LIMIT  = 100;
    localparam int GROUP_BYTES = IF_WIDTH * 4;
    localparam int LINE_BYTES  = fetch_pkg::LINE_BITS / 8;
    // Room for 250 groups at 20 cycles each
    localparam int TIMEOUT_NS  = 250 * 20 * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h7edad806;

    typedef logic [fetch_pkg::XLEN-1:0] group_t [IF_WIDTH];

    logic                            clk;
    logic                            rst;
    logic                            redirect;
    logic [fetch_pkg::XLEN-1:0]      redirect_pc;
    logic                            fetch_valid;
    logic                            fetch_ready;
    logic [fetch_pkg::XLEN-1:0]      fetch_pc;
    group_t                          fetch_insts;
    logic [fetch_pkg::XLEN-1:0]      dfp_addr;
    logic                            dfp_read;
    logic [fetch_pkg::LINE_BITS-1:0] dfp_rdata;
    logic                            dfp_resp;
    logic                            dfp_read_q;
    int                              fills;
    int                              errors = 0;
    int                              checks = 0;

    fetch_top #(
        .IF_WIDTH (IF_WIDTH),
        .NUM_SETS (NUM_SETS)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pc    (fetch_pc),
        .fetch_insts (fetch_insts),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_rdata   (dfp_rdata),
        .dfp_resp    (dfp_resp)
    );

    line_mem_model #(
        .DELAY (6)
    ) i_mem (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Count line refills by their dfp_read rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            dfp_read_q <= 1'b0;
            fills      <= 0;
        end else begin
            dfp_read_q <= dfp_read;
            if (dfp_read && !dfp_read_q) begin
                fills <= fills + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired at %0t, the tests did not finish", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [fetch_pkg::XLEN-1:0] expected_word(
        input logic [fetch_pkg::XLEN-1:0] addr
    );
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error %0t: %s", $time, msg);
    endtask

    task automatic check_addr(input string name, input logic [fetch_pkg::XLEN-1:0] got,
                              input logic [fetch_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_group(input string name, input group_t got, input group_t exp);
        for (int i = 0; i < IF_WIDTH; i++) begin
            checks++;
            if (got[i] !== exp[i]) begin
                errors++;
                $display("Fail %0t %s[%0d]: got %h expected %h", $time, name, i, got[i], exp[i]);
            end
        end
    endtask

    // Inputs change 1 ns after the edge, outputs are read 2 ns later
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic take_group(input logic [fetch_pkg::XLEN-1:0] exp_pc, input int stall_pct);
        group_t                     exp_insts;
        group_t                     held_insts;
        logic [fetch_pkg::XLEN-1:0] held_pc;
        logic                       held;
        int                         waited;
        held   = 1'b0;
        waited = 0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            exp_insts[i] = expected_word(exp_pc + 32'(4 * i));
        end
        while (waited < WAIT_LIMIT) begin
            fetch_ready = (stall_pct == 0) || ($urandom_range(99) >= stall_pct);
            #2;
            if (fetch_valid) begin
                if (held) begin
                    check_addr("fetch_pc held", fetch_pc, held_pc);
                    check_group("fetch_insts held", fetch_insts, held_insts);
                end
                if (fetch_ready) begin
                    check_addr("fetch_pc", fetch_pc, exp_pc);
                    check_group("fetch_insts", fetch_insts, exp_insts);
                    next_cycle();
                    fetch_ready = 1'b0;
                    return;
                end
                held       = 1'b1;
                held_pc    = fetch_pc;
                held_insts = fetch_insts;
            end else if (held) begin
                report_error("fetch_valid dropped while the consumer stalled");
                held = 1'b0;
            end
            next_cycle();
            waited++;
        end
        report_error($sformatf("no group for %h within %0d cycles", exp_pc, WAIT_LIMIT));
        fetch_ready = 1'b0;
    endtask

    // Stalled prefetch presented means the cache has gone quiet
    task automatic wait_group();
        int waited;
        waited      = 0;
        fetch_ready = 1'b0;
        #2;
        while (!fetch_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            #2;
            waited++;
        end
        next_cycle();
        if (waited == WAIT_LIMIT) begin
            report_error("no prefetched group presented while stalled");
        end
    endtask

    task automatic wait_fill();
        int waited;
        waited = 0;
        #2;
        while (!dfp_read && waited < WAIT_LIMIT) begin
            next_cycle();
            #2;
            waited++;
        end
        next_cycle();
        if (waited == WAIT_LIMIT) begin
            report_error("no line refill started after a redirect to a new line");
        end
    endtask

    task automatic redirect_to(input logic [fetch_pkg::XLEN-1:0] target);
        redirect    = 1'b1;
        redirect_pc = target;
        next_cycle();
        redirect = 1'b0;
    endtask

    task automatic test_reset();
        #2;
        if (fetch_valid !== 1'b0 || dfp_read !== 1'b0) begin
            report_error("fetch_valid or dfp_read high right after reset");
        end
        next_cycle();
        take_group(fetch_pkg::RESET_PC, 0);
    endtask

    task automatic test_stream();
        for (int g = 1; g <= 16; g++) begin
            take_group(fetch_pkg::RESET_PC + 32'(g * GROUP_BYTES), 0);
        end
    endtask

    task automatic test_hit_reuse();
        int fills_before;
        wait_group();
        fills_before = fills;
        redirect_to(fetch_pkg::RESET_PC + GROUP_BYTES);
        take_group(fetch_pkg::RESET_PC + GROUP_BYTES, 0);
        wait_group();
        if (fills != fills_before) begin
            report_error("line refill on an address that was already cached");
        end
    endtask

    task automatic test_backpressure();
        wait_group();
        redirect_to(32'h0000_0100);
        for (int g = 0; g < 24; g++) begin
            take_group(32'h0000_0100 + 32'(g * GROUP_BYTES), 50);
        end
    endtask

    task automatic test_redirect_miss();
        wait_group();
        redirect_to(32'h0000_0400);
        wait_fill();
        redirect_to(32'h0000_0868);
        take_group(32'h0000_0868, 0);
        take_group(32'h0000_0870, 0);
    endtask

    // Both addresses index the same set
    task automatic test_conflict();
        logic [fetch_pkg::XLEN-1:0] addr;
        int                         fills_before;
        for (int n = 0; n < 4; n++) begin
            addr = 32'h0000_1000 + ((n % 2 == 1) ? 32'(NUM_SETS * LINE_BYTES) : 32'h0);
            wait_group();
            fills_before = fills;
            redirect_to(addr);
            take_group(addr, 0);
            wait_group();
            if (fills != fills_before + 1) begin
                report_error($sformatf("expected one refill for %h, saw %0d",
                                       addr, fills - fills_before));
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        fetch_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_stream();
        test_hit_reuse();
        test_backpressure();
        test_redirect_miss();
        test_conflict();
        $display("Done: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/icache.sv
hdl/if1_stage.sv
hdl/fetch_top.sv
tests/line_mem_model.sv
tests/tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fetch
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
